// File: filelist.f
rtl/stage_geom_pkg.sv
rtl/stage_fmt_pkg.sv
rtl/b_col_unpack.sv
rtl/c_acc_unpack.sv
rtl/operand_stage_top.sv
verification/stage_checker.sv
verification/tb_operand_stage.sv

// File: rtl/b_col_unpack.sv
module b_col_unpack (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  stage_fmt_pkg::target_t                 target,
    input  stage_fmt_pkg::elem_t                   elem,
    input  stage_fmt_pkg::shape_t                  shape,
    input  logic [stage_geom_pkg::BURST_W-1:0]     burst_idx,
    input  logic [stage_geom_pkg::BEAT_W-1:0]      data_in,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]
                 [stage_geom_pkg::NUM_LANES-1:0]   b_we,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]
                 [stage_geom_pkg::NUM_LANES-1:0]
                 [stage_geom_pkg::NIB_W-1:0]       b_data
);

    logic b_hit;
    logic half;
    logic [stage_geom_pkg::NUM_BANKS-1:0][stage_geom_pkg::NUM_LANES-1:0] we_nxt;
    logic [stage_geom_pkg::NUM_BANKS-1:0]
          [stage_geom_pkg::NUM_LANES-1:0]
          [stage_geom_pkg::NIB_W-1:0]     data_nxt;

    // Illegal shapes drop the beat
    assign b_hit = in_valid && (target == stage_fmt_pkg::MAT_B)
                   && stage_fmt_pkg::shape_legal(shape);

    assign half = burst_idx[stage_geom_pkg::HALF_SEL_BIT];

    always_comb begin
        we_nxt   = '0;
        data_nxt = '0;
        if (b_hit) begin
            for (int i = 0; i < stage_geom_pkg::NUM_BANKS; i++) begin
                case (elem)
                    stage_fmt_pkg::FP32: begin
                        we_nxt[i]   = 8'hFF;
                        data_nxt[i] = data_in[stage_geom_pkg::WORD_W*i +: stage_geom_pkg::WORD_W];
                    end
                    stage_fmt_pkg::FP16: begin
                        if (shape == stage_fmt_pkg::M32N8) begin
                            // One halfword per bank, low nibbles only
                            we_nxt[i]         = 8'h0F;
                            data_nxt[i][3:0]  =
                                data_in[stage_geom_pkg::HALF_W*i +: stage_geom_pkg::HALF_W];
                        end else begin
                            we_nxt[i]   = 8'hFF;
                            data_nxt[i] = {
                                data_in[stage_geom_pkg::HALF_W*(i+8) +: stage_geom_pkg::HALF_W],
                                data_in[stage_geom_pkg::HALF_W*i     +: stage_geom_pkg::HALF_W]
                            };
                        end
                    end
                    stage_fmt_pkg::INT8: begin
                        case (shape)
                            stage_fmt_pkg::M32N8: begin
                                we_nxt[i] = 8'h03 << {half, 1'b0};
                                data_nxt[i][{half, 1'b0} +: 2] =
                                    data_in[stage_geom_pkg::BYTE_W*i +: stage_geom_pkg::BYTE_W];
                            end
                            stage_fmt_pkg::M16N16: begin
                                we_nxt[i] = 8'h0F << {half, 2'b00};
                                data_nxt[i][{half, 2'b00} +: 4] = {
                                    data_in[stage_geom_pkg::BYTE_W*(i+8) +: stage_geom_pkg::BYTE_W],
                                    data_in[stage_geom_pkg::BYTE_W*i     +: stage_geom_pkg::BYTE_W]
                                };
                            end
                            stage_fmt_pkg::M8N32: begin
                                we_nxt[i]   = 8'hFF; // Four bytes fill the bank
                                data_nxt[i] = {
                                    data_in[stage_geom_pkg::BYTE_W*(i+24) +: stage_geom_pkg::BYTE_W],
                                    data_in[stage_geom_pkg::BYTE_W*(i+16) +: stage_geom_pkg::BYTE_W],
                                    data_in[stage_geom_pkg::BYTE_W*(i+8)  +: stage_geom_pkg::BYTE_W],
                                    data_in[stage_geom_pkg::BYTE_W*i      +: stage_geom_pkg::BYTE_W]
                                };
                            end
                            default: begin
                                we_nxt[i] = '0;
                            end
                        endcase
                    end
                    default: begin
                        we_nxt[i] = '0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_we <= '0;
        end else begin
            b_we <= we_nxt;
        end
    end

    always_ff @(posedge clk) begin
        b_data <= data_nxt;
    end

    // Upstream must never send shape code 3 to the B store
    b_shape_legal: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && target == stage_fmt_pkg::MAT_B) |-> stage_fmt_pkg::shape_legal(shape)
    ) else $error("B beat with illegal shape code %0d", shape);

endmodule

// File: rtl/c_acc_unpack.sv
module c_acc_unpack (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  stage_fmt_pkg::target_t                target,
    input  stage_fmt_pkg::elem_t                  elem,
    input  stage_fmt_pkg::shape_t                 shape,
    input  logic                                  mixed,
    input  logic [stage_geom_pkg::BURST_W-1:0]    burst_idx,
    input  logic [stage_geom_pkg::BEAT_W-1:0]     data_in,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]  c_we,
    output logic [stage_geom_pkg::NUM_LANES-1:0]
                 [stage_geom_pkg::ACC_W-1:0]      c_data
);

    logic c_hit;
    logic [stage_geom_pkg::ROW_IDX_W-1:0] row_idx;
    logic [stage_geom_pkg::NUM_BANKS-1:0] we_nxt;
    logic [stage_geom_pkg::NUM_LANES-1:0][stage_geom_pkg::ACC_W-1:0] data_nxt;

    assign c_hit = in_valid && (target == stage_fmt_pkg::MAT_C)
                   && stage_fmt_pkg::shape_legal(shape);

    // Row index depends on how many beats make up one row
    always_comb begin
        case (shape)
            stage_fmt_pkg::M32N8:  row_idx = burst_idx[2:0];
            stage_fmt_pkg::M16N16: row_idx = burst_idx[3:1];
            stage_fmt_pkg::M8N32:  row_idx = burst_idx[4:2];
            default:               row_idx = '0;
        endcase
    end

    always_comb begin
        we_nxt = '0;
        if (c_hit) begin
            we_nxt[row_idx] = 1'b1;
        end
    end

    // Lane extension, computed every cycle
    always_comb begin : lane_ext
        logic [stage_geom_pkg::HALF_W-1:0] h16;
        logic [stage_geom_pkg::BYTE_W-1:0] b8;

        h16      = '0;
        b8       = '0;
        data_nxt = '0;
        for (int k = 0; k < stage_geom_pkg::NUM_LANES; k++) begin
            h16 = data_in[stage_geom_pkg::HALF_W*k +: stage_geom_pkg::HALF_W];
            b8  = data_in[stage_geom_pkg::BYTE_W*k +: stage_geom_pkg::BYTE_W];
            case (elem)
                stage_fmt_pkg::FP16: begin
                    if (mixed) begin
                        // Mixed precision keeps the raw word
                        data_nxt[k] = data_in[stage_geom_pkg::WORD_W*k +: stage_geom_pkg::WORD_W];
                    end else begin
                        data_nxt[k] = {{(stage_geom_pkg::ACC_W-stage_geom_pkg::HALF_W){1'b0}},
                                       h16};
                    end
                end
                stage_fmt_pkg::INT8: begin
                    data_nxt[k] = {{(stage_geom_pkg::ACC_W-stage_geom_pkg::BYTE_W)
                                    {b8[stage_geom_pkg::BYTE_W-1]}}, b8};
                end
                default: begin
                    data_nxt[k] = data_in[stage_geom_pkg::WORD_W*k +: stage_geom_pkg::WORD_W];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            c_we <= '0;
        end else begin
            c_we <= we_nxt;
        end
    end

    always_ff @(posedge clk) begin
        c_data <= data_nxt;
    end

    c_shape_legal: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && target == stage_fmt_pkg::MAT_C) |-> stage_fmt_pkg::shape_legal(shape)
    ) else $error("C beat with illegal shape code %0d", shape);

endmodule

// File: rtl/operand_stage_top.sv
module operand_stage_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  logic                                  mixed,
    input  logic [stage_geom_pkg::BEAT_W-1:0]     data_in,
    input  logic [stage_geom_pkg::BURST_W-1:0]    burst_idx,
    input  stage_fmt_pkg::elem_t                  elem,
    input  stage_fmt_pkg::target_t                target,
    input  stage_fmt_pkg::shape_t                 shape,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]
                 [stage_geom_pkg::NUM_LANES-1:0]  b_we,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]
                 [stage_geom_pkg::NUM_LANES-1:0]
                 [stage_geom_pkg::NIB_W-1:0]      b_data,
    output logic [stage_geom_pkg::NUM_BANKS-1:0]  c_we,
    output logic [stage_geom_pkg::NUM_LANES-1:0]
                 [stage_geom_pkg::ACC_W-1:0]      c_data
);

    // Same beat fields go to both paths, each checks its own target
    b_col_unpack b_col_unpack_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .target    (target),
        .elem      (elem),
        .shape     (shape),
        .burst_idx (burst_idx),
        .data_in   (data_in),
        .b_we      (b_we),
        .b_data    (b_data)
    );

    c_acc_unpack c_acc_unpack_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .target    (target),
        .elem      (elem),
        .shape     (shape),
        .mixed     (mixed),
        .burst_idx (burst_idx),
        .data_in   (data_in),
        .c_we      (c_we),
        .c_data    (c_data)
    );

endmodule

// File: rtl/stage_fmt_pkg.sv
package stage_fmt_pkg;

    // Element type of the beat
    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1,
        INT8 = 2'd2
    } elem_t;

    // Destination of the beat
    typedef enum logic {
        MAT_B = 1'b0,
        MAT_C = 1'b1
    } target_t;

    // Tile shape, code 3 is not a valid shape
    typedef enum logic [1:0] {
        M32N8  = 2'd0,
        M16N16 = 2'd1,
        M8N32  = 2'd2
    } shape_t;

    // True for the three defined shape codes
    function automatic logic shape_legal(shape_t s);
        return s inside {M32N8, M16N16, M8N32};
    endfunction

endpackage

// File: rtl/stage_geom_pkg.sv
package stage_geom_pkg;

    // Burst beat from memory
    localparam int BEAT_W  = 256;
    localparam int BURST_W = 6;   // Burst index, up to 64 beats per tile

    // B operand store banks; the same count gives the C rows
    localparam int NUM_BANKS = 8;
    localparam int NUM_LANES = 8; // Lanes per bank or per row

    // B lanes are nibbles
    localparam int NIB_W = 4;

    // C preload lanes are full accumulator words
    localparam int ACC_W = 32;

    // Element widths within a beat
    localparam int WORD_W = 32;
    localparam int HALF_W = 16;
    localparam int BYTE_W = 8;

    // Row select into the array for the C path
    localparam int ROW_IDX_W = $clog2(NUM_BANKS);

    // Burst bit picking the nibble half of a partly filled B bank
    localparam int HALF_SEL_BIT = 3;

endpackage

// File: verification/stage_checker.sv
module stage_checker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  logic                                  mixed,
    input  stage_fmt_pkg::target_t                target,
    input  stage_fmt_pkg::elem_t                  elem,
    input  stage_fmt_pkg::shape_t                 shape,
    input  logic [stage_geom_pkg::BURST_W-1:0]    burst_idx,
    input  logic [stage_geom_pkg::BEAT_W-1:0]     data_in,
    input  logic [127:0]                          test_name,
    input  logic [63:0]                           b_we,
    input  logic [255:0]                          b_data,
    input  logic [stage_geom_pkg::NUM_BANKS-1:0]  c_we,
    input  logic [255:0]                          c_data,
    output int                                    test_count,
    output int                                    err_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_tests = 0;
    int n_errs  = 0;
    logic pending = 1'b0;
    logic [127:0] exp_name;
    logic [63:0]  exp_b_we, nb_we;
    logic [255:0] exp_b_data, nb_data, nib_mask;
    logic [7:0]   exp_c_we, nc_we;
    logic [255:0] exp_c_data, nc_data;
    logic [39:0]  bank;

    assign test_count = n_tests;
    assign err_count  = n_errs;

    // Returns {enables, bank word} for bank i
    function automatic logic [39:0] b_bank(input logic [255:0] beat,
                                           input stage_fmt_pkg::elem_t e,
                                           input stage_fmt_pkg::shape_t s,
                                           input logic h, input int i);
        logic [31:0] payload;
        logic [7:0]  we;
        int base;
        int cnt;
        payload = '0;
        base    = 0;
        cnt     = 0;
        if (e == stage_fmt_pkg::FP32) begin
            payload = beat[32*i +: 32];
            cnt     = 8;
        end else if (e == stage_fmt_pkg::FP16) begin
            if (s == stage_fmt_pkg::M32N8) begin
                payload = beat[16*i +: 16];
                cnt     = 4;
            end else begin
                payload = {beat[16*(i+8) +: 16], beat[16*i +: 16]};
                cnt     = 8;
            end
        end else if (s == stage_fmt_pkg::M32N8) begin
            payload = beat[8*i +: 8];
            cnt     = 2;
            base    = 2 * h; // Nibble pair picked by burst bit 3
        end else if (s == stage_fmt_pkg::M16N16) begin
            payload = {beat[8*(i+8) +: 8], beat[8*i +: 8]};
            cnt     = 4;
            base    = 4 * h;
        end else begin
            payload = {beat[8*(i+24) +: 8], beat[8*(i+16) +: 8],
                       beat[8*(i+8) +: 8], beat[8*i +: 8]};
            cnt     = 8;
        end
        we = 8'(((1 << cnt) - 1) << base);
        return {we, payload << (4 * base)};
    endfunction

    function automatic logic [7:0] c_row_we(input stage_fmt_pkg::shape_t s,
                                            input logic [5:0] burst);
        int beats_per_row_log;
        beats_per_row_log = (s == stage_fmt_pkg::M32N8) ? 0 :
                            (s == stage_fmt_pkg::M16N16) ? 1 : 2;
        return 8'(1 << (int'(burst >> beats_per_row_log) % 8));
    endfunction

    function automatic logic [31:0] c_lane(input logic [255:0] beat,
                                           input stage_fmt_pkg::elem_t e,
                                           input logic mx, input int k);
        logic [7:0] b8;
        b8 = beat[8*k +: 8];
        if (e == stage_fmt_pkg::INT8) return int'($signed(b8));
        if (e == stage_fmt_pkg::FP16 && !mx) return {16'h0000, beat[16*k +: 16]};
        return beat[32*k +: 32];
    endfunction

    // Prediction from the beat seen at this edge
    always @(posedge clk) begin : capture
        nb_we   = '0;
        nb_data = '0;
        nc_we   = '0;
        nc_data = '0;
        if (!rst && in_valid) begin
            if (target == stage_fmt_pkg::MAT_B) begin
                for (int i = 0; i < 8; i++) begin
                    bank = b_bank(data_in, elem, shape, burst_idx[3], i);
                    nb_we[8*i +: 8]    = bank[39:32];
                    nb_data[32*i +: 32] = bank[31:0];
                end
            end else begin
                nc_we = c_row_we(shape, burst_idx);
                for (int k = 0; k < 8; k++) nc_data[32*k +: 32] = c_lane(data_in, elem, mixed, k);
            end
        end
        exp_b_we   <= nb_we;
        exp_b_data <= nb_data;
        exp_c_we   <= nc_we;
        exp_c_data <= nc_data;
        exp_name   <= test_name;
        pending    <= 1'b1;
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin : compare
        int errs;
        if (pending) begin
            errs = 0;
            for (int i = 0; i < 64; i++) nib_mask[4*i +: 4] = {4{exp_b_we[i]}};
            if (b_we !== exp_b_we) begin
                $display("FAIL t=%0t b_we expected %h actual %h", $time, exp_b_we, b_we);
                errs++;
            end
            if ((b_data & nib_mask) !== (exp_b_data & nib_mask)) begin
                $display("FAIL t=%0t b_data expected %h actual %h", $time,
                         exp_b_data & nib_mask, b_data & nib_mask);
                errs++;
            end
            if (c_we !== exp_c_we) begin
                $display("FAIL t=%0t c_we expected %h actual %h", $time, exp_c_we, c_we);
                errs++;
            end
            if (exp_c_we != '0 && c_data !== exp_c_data) begin
                $display("FAIL t=%0t c_data expected %h actual %h", $time, exp_c_data, c_data);
                errs++;
            end
            n_tests++;
            n_errs += errs;
            if (errs == 0) $display("%0t ns  %0s  ok", $time, exp_name);
            else $display("%0t ns  %0s  %0d mismatches", $time, exp_name, errs);
        end
    end

endmodule

// File: verification/tb_operand_stage.sv
module tb_operand_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS     = 160;
    localparam int RESET_CYCLES = 4;
    localparam int CLK_HALF     = 10;
    localparam int NAME_W       = 128;

    logic clk = 1'b0;
    logic rst, in_valid, mixed;
    logic [stage_geom_pkg::BEAT_W-1:0]  data_in;
    logic [stage_geom_pkg::BURST_W-1:0] burst_idx;
    stage_fmt_pkg::elem_t   elem;
    stage_fmt_pkg::target_t target;
    stage_fmt_pkg::shape_t  shape;
    logic [7:0][7:0]        b_we;
    logic [7:0][7:0][3:0]   b_data;
    logic [7:0]             c_we;
    logic [7:0][31:0]       c_data;
    logic [NAME_W-1:0]      cur_name;
    int test_count, err_count;

    // Stimulus table, one column per field
    stage_fmt_pkg::target_t tgt_col   [MAX_ROWS];
    stage_fmt_pkg::elem_t   elem_col  [MAX_ROWS];
    stage_fmt_pkg::shape_t  shape_col [MAX_ROWS];
    logic                   mixed_col [MAX_ROWS];
    logic [5:0]             burst_col [MAX_ROWS];
    logic                   valid_col [MAX_ROWS];
    logic [255:0]           beat_col  [MAX_ROWS];
    logic [NAME_W-1:0]      name_col  [MAX_ROWS];
    int   n_rows;
    logic table_ready;

    always #CLK_HALF clk = ~clk;

    operand_stage_top operand_stage_top_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .mixed(mixed),
        .data_in(data_in), .burst_idx(burst_idx), .elem(elem), .target(target),
        .shape(shape), .b_we(b_we), .b_data(b_data), .c_we(c_we), .c_data(c_data)
    );

    stage_checker checker_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .mixed(mixed), .target(target),
        .elem(elem), .shape(shape), .burst_idx(burst_idx), .data_in(data_in),
        .test_name(cur_name), .b_we(b_we), .b_data(b_data), .c_we(c_we),
        .c_data(c_data), .test_count(test_count), .err_count(err_count)
    );

    task automatic add_row(input stage_fmt_pkg::target_t t, input stage_fmt_pkg::elem_t e,
                           input stage_fmt_pkg::shape_t s, input logic m,
                           input logic [5:0] b, input logic v, input logic [NAME_W-1:0] nm);
        logic [255:0] beat;
        for (int w = 0; w < 8; w++) beat[32*w +: 32] = $urandom();
        if (e == stage_fmt_pkg::INT8) beat |= {16{16'h0080}}; // Every other byte negative
        tgt_col[n_rows]   = t;
        elem_col[n_rows]  = e;
        shape_col[n_rows] = s;
        mixed_col[n_rows] = m;
        burst_col[n_rows] = b;
        valid_col[n_rows] = v;
        beat_col[n_rows]  = beat;
        name_col[n_rows]  = nm;
        n_rows++;
    endtask

    task automatic build_table();
        logic [NAME_W-1:0] nm;
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 0, 0, "idle");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP32, stage_fmt_pkg::M16N16, 0, 3, 1,
                "b_fp32");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP16, stage_fmt_pkg::M32N8, 0, 1, 1,
                "b_fp16_m32n8");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP16, stage_fmt_pkg::M16N16, 0, 9, 1,
                "b_fp16_m16n16");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP16, stage_fmt_pkg::M8N32, 1, 12, 1,
                "b_fp16_m8n32");
        for (int h = 0; h < 2; h++) begin
            add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::INT8, stage_fmt_pkg::M32N8, 0,
                    6'(8*h + 2), 1, h ? "b_int8_m32n8_h1" : "b_int8_m32n8_h0");
            add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::INT8, stage_fmt_pkg::M16N16, 0,
                    6'(8*h + 5), 1, h ? "b_int8_m16_h1" : "b_int8_m16_h0");
            add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::INT8, stage_fmt_pkg::M8N32, 0,
                    6'(8*h + 1), 1, h ? "b_int8_m8n32_h1" : "b_int8_m8n32_h0");
        end
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 0, 0, "idle");
        // Row select sweep, every burst index for every shape
        for (int s = 0; s < 3; s++) begin
            nm = (s == 0) ? "c_row_m32n8" : (s == 1) ? "c_row_m16n16" : "c_row_m8n32";
            for (int b = 0; b < 32; b++)
                add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::elem_t'(b % 3),
                        stage_fmt_pkg::shape_t'(s), 1'(b), 6'(b), 1, nm);
        end
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 4, 1,
                "c_fp32");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP16, stage_fmt_pkg::M16N16, 1, 6, 1,
                "c_fp16_mixed");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP16, stage_fmt_pkg::M16N16, 0, 7, 1,
                "c_fp16_zext");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::INT8, stage_fmt_pkg::M8N32, 0, 21, 1,
                "c_int8_sext");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 0, 0, "idle");
        // Back to back, alternating destinations
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 1, 1,
                "b2b_b_fp32");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::INT8, stage_fmt_pkg::M16N16, 0, 5, 1,
                "b2b_c_int8");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::INT8, stage_fmt_pkg::M32N8, 0, 9, 1,
                "b2b_b_int8");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP16, stage_fmt_pkg::M8N32, 1, 20, 1,
                "b2b_c_fp16");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP16, stage_fmt_pkg::M16N16, 0, 14, 1,
                "b2b_b_fp16");
        add_row(stage_fmt_pkg::MAT_C, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 30, 1,
                "b2b_c_fp32");
        add_row(stage_fmt_pkg::MAT_B, stage_fmt_pkg::FP32, stage_fmt_pkg::M32N8, 0, 0, 0, "idle");
    endtask

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        mixed       = 1'b0;
        data_in     = '0;
        burst_idx   = '0;
        elem        = stage_fmt_pkg::FP32;
        target      = stage_fmt_pkg::MAT_B;
        shape       = stage_fmt_pkg::M32N8;
        cur_name    = "reset";
        n_rows      = 0;
        table_ready = 1'b0;
        void'($urandom(37765));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            target    <= tgt_col[r];
            elem      <= elem_col[r];
            shape     <= shape_col[r];
            mixed     <= mixed_col[r];
            burst_idx <= burst_col[r];
            in_valid  <= valid_col[r];
            data_in   <= beat_col[r];
            cur_name  <= name_col[r];
            @(posedge clk);
        end
        in_valid <= 1'b0;
        cur_name <= "tail_idle";
        @(posedge clk);
        @(posedge clk); // Tail result compared on the falling edge before this
        $display("Tests run %0d, mismatches %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = (n_rows + RESET_CYCLES + 20) * 2 * CLK_HALF;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule
